// File: all.f
hdl/soc_bus_pkg.sv
hdl/data_ram.sv
hdl/keyboard_port.sv
hdl/sd_bridge.sv
hdl/bus_fabric.sv
hdl/board_bus_top.sv
tests/tb_board_bus.sv

// File: tests/tb_board_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_bus import soc_bus_pkg::*; ();

    localparam int RAM_WORDS       = 1024;
    localparam int REGION_WORDS    = 64;
    localparam int SUB_STORES      = 24;
    localparam int LOADS_PER_TYPE  = 6;
    localparam int DW_ROUNDS       = 8;
    localparam int BUF_READS       = 20;
    localparam int BUS_OPS         = REGION_WORDS + SUB_STORES + 6 * LOADS_PER_TYPE
                                     + 4 * DW_ROUNDS + BUF_READS + 8 + 24;
    localparam int WATCHDOG_CYCLES = BUS_OPS * 4 + SD_BUF_BYTES * 6 + 200;

    logic CLOCK_50, KEY0, rd_req, wr_req, irq_ack, key_pressed;
    logic sd_ready, sd_byte_valid, rd_done, wr_done, irq, sd_rd_start;
    logic [7:0]  key_ascii, sd_byte, exp_char;
    logic [31:0] sd_sector;
    bus_req_t    req;
    bus_data_t   rd_data, got, d;
    bus_addr_t   a;
    console_t    console;

    logic [7:0] ram_model [RAM_WORDS * 4];
    logic [7:0] sd_model [SD_BUF_BYTES];
    integer seed = 32'hec3;
    int value_errors = 0;
    int protocol_errors = 0;
    int con_count = 0;
    int start_count = 0;
    logic con_prev = 1'b0;
    logic start_prev = 1'b0;
    int w, off, sz, n;

    board_bus_top #(.RAM_WORDS(RAM_WORDS)) UUT (
        .CLOCK_50, .KEY0, .rd_req, .wr_req, .req, .irq_ack, .key_ascii,
        .key_pressed, .sd_ready, .sd_byte, .sd_byte_valid, .rd_done, .rd_data,
        .wr_done, .irq, .console, .sd_rd_start, .sd_sector
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    task automatic check_value(input string name, input bus_data_t expected,
                               input bus_data_t actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic bus_read(input bus_addr_t addr, input access_t size,
                            output bus_data_t data);
        int   cycles;
        logic seen;
        @(posedge CLOCK_50);
        #1;
        req.addr  = addr;
        req.wdata = '0;
        req.size  = size;
        rd_req    = 1'b1;
        @(posedge CLOCK_50);
        #1;
        rd_req = 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 4) begin
            @(negedge CLOCK_50);
            cycles++;
            seen = rd_done;
        end
        assert (seen) else begin
            protocol_errors++;
            $display("read of address %h got no rd_done within 4 cycles (%0t ns)", addr, $time);
        end
        data = rd_data;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data,
                             input access_t size);
        int   cycles;
        logic seen;
        @(posedge CLOCK_50);
        #1;
        req.addr  = addr;
        req.wdata = data;
        req.size  = size;
        wr_req    = 1'b1;
        @(posedge CLOCK_50);
        #1;
        wr_req = 1'b0;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 4) begin
            @(negedge CLOCK_50);
            cycles++;
            seen = wr_done;
        end
        assert (seen) else begin
            protocol_errors++;
            $display("write to address %h got no wr_done within 4 cycles (%0t ns)", addr, $time);
        end
    endtask

    // RAM store that also updates the byte model
    task automatic store(input bus_addr_t addr, input bus_data_t data, input access_t size);
        int base;
        base = int'(addr - RAM_BASE);
        bus_write(addr, data, size);
        for (int i = 0; i < (1 << size[1:0]); i++) begin
            ram_model[base + i] = data[8*i +: 8];
        end
    endtask

    // little-endian gather from the model, then extend
    function automatic bus_data_t expected_load(input bus_addr_t addr, input access_t size);
        int        base;
        bus_data_t raw;
        base = int'(addr - RAM_BASE);
        raw  = '0;
        for (int i = 0; i < (1 << size[1:0]); i++) begin
            raw[8*i +: 8] = ram_model[base + i];
        end
        case (size)
            ACC_LB:  return {{56{raw[7]}}, raw[7:0]};
            ACC_LH:  return {{48{raw[15]}}, raw[15:0]};
            ACC_LW:  return {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    function automatic bus_data_t expected_sector(input int start);
        bus_data_t v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            if (start + i < SD_BUF_BYTES) begin
                v[8*i +: 8] = sd_model[start + i];
            end
        end
        return v;
    endfunction

    task automatic load_check(input bus_addr_t addr, input access_t size);
        bus_data_t v;
        bus_read(addr, size, v);
        check_value("rd_data", expected_load(addr, size), v);
    endtask

    // console and sd_rd_start are single-cycle pulses
    always @(negedge CLOCK_50) begin
        if (KEY0) begin
            if (console.valid) begin
                con_count++;
                check_value("console.char", {56'd0, exp_char}, {56'd0, console.char});
                assert (!con_prev) else begin
                    protocol_errors++;
                    $display("console.valid held high for more than one cycle at %0t ns", $time);
                end
            end
            if (sd_rd_start) begin
                start_count++;
                assert (!start_prev) else begin
                    protocol_errors++;
                    $display("sd_rd_start held high for more than one cycle at %0t ns", $time);
                end
            end
        end
        con_prev   = console.valid;
        start_prev = sd_rd_start;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
        $display("value errors: %0d, handshake errors: %0d", value_errors, protocol_errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        KEY0 = 1'b0;
        rd_req = 1'b0;
        wr_req = 1'b0;
        req = '0;
        irq_ack = 1'b0;
        key_ascii = 8'd0;
        key_pressed = 1'b0;
        sd_ready = 1'b0;
        sd_byte = 8'd0;
        sd_byte_valid = 1'b0;
        exp_char = 8'd0;
        repeat (3) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;

        repeat (2) begin
            @(negedge CLOCK_50);
            check_value("rd_done", 64'd0, {63'd0, rd_done});
            check_value("wr_done", 64'd0, {63'd0, wr_done});
            check_value("irq", 64'd0, {63'd0, irq});
            check_value("console.valid", 64'd0, {63'd0, console.valid});
            check_value("sd_rd_start", 64'd0, {63'd0, sd_rd_start});
        end

        // fill the test region with a pattern over the whole address
        for (w = 0; w < REGION_WORDS; w++) begin
            a = RAM_BASE + bus_addr_t'(4 * w);
            store(a, {32'd0, (a[31:0] * 32'h9e37_79b1) ^ {a[15:0], a[31:16]}}, ACC_LW);
        end

        // sub-word stores at aligned random offsets
        for (n = 0; n < SUB_STORES; n++) begin
            sz  = {$random(seed)} % 3;
            off = ({$random(seed)} % 4) & ~((1 << sz) - 1);
            w   = {$random(seed)} % REGION_WORDS;
            d   = {$random(seed), $random(seed)};
            store(RAM_BASE + bus_addr_t'(4 * w + off), d, access_t'(sz));
        end
        for (int t = 0; t < 7; t++) begin
            if (t != ACC_LD) begin
                for (n = 0; n < LOADS_PER_TYPE; n++) begin
                    off = ({$random(seed)} % 4) & ~((1 << t[1:0]) - 1);
                    w   = {$random(seed)} % REGION_WORDS;
                    load_check(RAM_BASE + bus_addr_t'(4 * w + off), access_t'(t));
                end
            end
        end

        // doublewords mixed with byte stores
        for (n = 0; n < DW_ROUNDS; n++) begin
            w = {$random(seed)} % (REGION_WORDS - 1);
            a = RAM_BASE + bus_addr_t'(4 * w);
            store(a, {$random(seed), $random(seed)}, ACC_LD);
            store(a + bus_addr_t'({$random(seed)} % 8), bus_data_t'($random(seed)), ACC_LB);
            load_check(a, ACC_LD);
            w = {$random(seed)} % (REGION_WORDS - 1);
            load_check(RAM_BASE + bus_addr_t'(4 * w), ACC_LD);
        end

        // keyboard press, readback and acknowledge
        @(posedge CLOCK_50);
        #1;
        key_ascii   = 8'h41;
        key_pressed = 1'b1;
        @(posedge CLOCK_50);
        #1;
        key_pressed = 1'b0;
        @(negedge CLOCK_50);
        check_value("irq", 64'd1, {63'd0, irq});
        bus_read(KEY_ADDR, ACC_LD, got);
        check_value("rd_data", 64'h41, got);
        @(posedge CLOCK_50);
        #1;
        irq_ack = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_ack = 1'b0;
        @(negedge CLOCK_50);
        check_value("irq", 64'd0, {63'd0, irq});
        // zero code updates key_code only
        @(posedge CLOCK_50);
        #1;
        key_ascii   = 8'd0;
        key_pressed = 1'b1;
        @(posedge CLOCK_50);
        #1;
        key_pressed = 1'b0;
        @(negedge CLOCK_50);
        check_value("irq", 64'd0, {63'd0, irq});
        bus_read(KEY_ADDR, ACC_LD, got);
        check_value("rd_data", 64'd0, got);

        // SD sector register and start strobe
        d = {$random(seed), $random(seed)};
        bus_write(SD_SECTOR_ADDR, d, ACC_LD);
        check_value("sd_sector", {32'd0, d[31:0]}, {32'd0, sd_sector});
        bus_write(SD_START_ADDR, 64'd1, ACC_LD);
        repeat (2) @(negedge CLOCK_50);
        check_value("sd_rd_start pulse count", 64'd1, bus_data_t'(start_count));

        // stream one sector
        bus_read(SD_AVAIL_ADDR, ACC_LD, got);
        check_value("rd_data", 64'd0, got);
        for (n = 0; n < SD_BUF_BYTES; n++) begin
            sd_model[n] = 8'($random(seed));
            @(posedge CLOCK_50);
            #1;
            sd_byte       = sd_model[n];
            sd_byte_valid = 1'b1;
            @(posedge CLOCK_50);
            #1;
            sd_byte_valid = 1'b0;
            if (n % 64 == 63 && n != SD_BUF_BYTES - 1) begin
                bus_read(SD_AVAIL_ADDR, ACC_LD, got);
                check_value("rd_data", 64'd0, got);
            end
        end
        bus_read(SD_AVAIL_ADDR, ACC_LD, got);
        check_value("rd_data", 64'd1, got);
        for (n = 0; n < BUF_READS; n++) begin
            case (n)
                0:       off = 0;
                1:       off = 504;
                2:       off = 505;
                3:       off = 511;
                default: off = {$random(seed)} % SD_BUF_BYTES;
            endcase
            bus_read(SD_BUF_BASE + bus_addr_t'(off), ACC_LD, got);
            check_value("rd_data", expected_sector(off), got);
        end

        // ready passes a two-flop synchronizer
        for (n = 1; n >= 0; n--) begin
            @(posedge CLOCK_50);
            #1;
            sd_ready = n[0];
            repeat (3) @(posedge CLOCK_50);
            bus_read(SD_READY_ADDR, ACC_LD, got);
            check_value("rd_data", bus_data_t'(n), got);
        end

        // console characters
        for (n = 0; n < 4; n++) begin
            d        = {$random(seed), $random(seed)};
            exp_char = d[7:0];
            w        = con_count;
            bus_write(CONSOLE_ADDR, d, ACC_LD);
            repeat (2) @(negedge CLOCK_50);
            check_value("console.valid pulse count", bus_data_t'(w + 1), bus_data_t'(con_count));
        end

        // unmapped space, each read right after one that returns a one
        bus_read(SD_AVAIL_ADDR, ACC_LD, got);
        check_value("rd_data", 64'd1, got);
        bus_read(64'h0000_5000, ACC_LD, got);
        check_value("rd_data", 64'd0, got);
        bus_read(SD_AVAIL_ADDR, ACC_LD, got);
        check_value("rd_data", 64'd1, got);
        bus_read(64'h0000_9030, ACC_LW, got);
        check_value("rd_data", 64'd0, got);
        bus_write(64'h0000_5008, 64'h1234, ACC_LD);

        repeat (2) @(posedge CLOCK_50);
        $display("value errors: %0d, handshake errors: %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/board_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_bus_top import soc_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  wire         CLOCK_50,
    input  wire         KEY0,
    input  logic        rd_req,
    input  logic        wr_req,
    input  bus_req_t    req,
    input  logic        irq_ack,
    input  logic [7:0]  key_ascii,
    input  logic        key_pressed,
    input  logic        sd_ready,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_valid,
    output logic        rd_done,
    output bus_data_t   rd_data,
    output logic        wr_done,
    output logic        irq,
    output console_t    console,
    output logic        sd_rd_start,
    output logic [31:0] sd_sector
);

    logic       ram_rd, ram_wr, ram_rd_done, ram_wr_done;
    bus_data_t  ram_rd_data;
    logic [7:0] key_code;
    logic       sector_wr, start_wr, sd_avail, sd_ready_q;
    logic [8:0] buf_offset;
    bus_data_t  buf_data;

    bus_fabric #(.RAM_WORDS(RAM_WORDS)) u_fabric (
        .CLOCK_50, .KEY0, .rd_req, .wr_req, .req,
        .ram_rd_done, .ram_rd_data, .ram_wr_done, .key_code, .buf_data,
        .sd_avail, .sd_ready_q, .rd_done, .rd_data, .wr_done, .ram_rd,
        .ram_wr, .sector_wr, .start_wr, .buf_offset, .console
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .CLOCK_50, .KEY0, .ram_rd, .ram_wr, .req,
        .ram_rd_done, .ram_rd_data, .ram_wr_done
    );

    keyboard_port u_keyboard (
        .CLOCK_50, .KEY0, .key_ascii, .key_pressed, .irq_ack, .key_code, .irq
    );

    sd_bridge u_sd (
        .CLOCK_50, .KEY0, .sector_wr, .start_wr, .wdata(req.wdata), .buf_offset,
        .sd_ready, .sd_byte, .sd_byte_valid, .sd_sector, .sd_rd_start,
        .buf_data, .sd_avail, .sd_ready_q
    );

endmodule

`default_nettype wire

// File: hdl/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric import soc_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  logic       rd_req,
    input  logic       wr_req,
    input  bus_req_t   req,
    input  logic       ram_rd_done,
    input  bus_data_t  ram_rd_data,
    input  logic       ram_wr_done,
    input  logic [7:0] key_code,
    input  bus_data_t  buf_data,
    input  logic       sd_avail,
    input  logic       sd_ready_q,
    output logic       rd_done,
    output bus_data_t  rd_data,
    output logic       wr_done,
    output logic       ram_rd,
    output logic       ram_wr,
    output logic       sector_wr,
    output logic       start_wr,
    output logic [8:0] buf_offset,
    output console_t   console
);

    localparam bus_addr_t RAM_END = RAM_BASE + bus_addr_t'(RAM_WORDS) * 64'd4;

    logic sel_ram, sel_buf, sel_key, sel_console;
    logic sel_sector, sel_start, sel_ready, sel_avail;

    bus_addr_t buf_off_full;
    bus_data_t rd_value;
    bus_data_t reg_rd_data;
    logic      reg_rd_done;
    logic      reg_wr_done;
    logic      con_valid;
    logic [7:0] con_char;

    // address decode
    assign sel_ram     = (req.addr >= RAM_BASE) && (req.addr < RAM_END);
    assign sel_buf     = (req.addr >= SD_BUF_BASE) &&
                         (req.addr < SD_BUF_BASE + bus_addr_t'(SD_BUF_BYTES));
    assign sel_key     = (req.addr == KEY_ADDR);
    assign sel_console = (req.addr == CONSOLE_ADDR);
    assign sel_sector  = (req.addr == SD_SECTOR_ADDR);
    assign sel_start   = (req.addr == SD_START_ADDR);
    assign sel_ready   = (req.addr == SD_READY_ADDR);
    assign sel_avail   = (req.addr == SD_AVAIL_ADDR);

    assign ram_rd       = rd_req && sel_ram;
    assign ram_wr       = wr_req && sel_ram;
    assign sector_wr    = wr_req && sel_sector;
    assign start_wr     = wr_req && sel_start;
    assign buf_off_full = req.addr - SD_BUF_BASE;
    assign buf_offset   = buf_off_full[8:0];

    // unmapped reads give zero
    always_comb begin
        if (sel_key)        rd_value = {56'd0, key_code};
        else if (sel_buf)   rd_value = buf_data;
        else if (sel_ready) rd_value = {63'd0, sd_ready_q};
        else if (sel_avail) rd_value = {63'd0, sd_avail};
        else                rd_value = '0;
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_req) begin
            reg_rd_data <= rd_value;
        end
        if (wr_req && sel_console) begin
            con_char <= req.wdata[7:0];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            reg_rd_done <= 1'b0;
            reg_wr_done <= 1'b0;
            con_valid   <= 1'b0;
        end else begin
            reg_rd_done <= rd_req && !sel_ram;
            reg_wr_done <= wr_req && !sel_ram;
            con_valid   <= wr_req && sel_console;
        end
    end

    assign console = '{valid: con_valid, char: con_char};

    // RAM answers pass straight through
    assign rd_done = reg_rd_done || ram_rd_done;
    assign wr_done = reg_wr_done || ram_wr_done;
    assign rd_data = ram_rd_done ? ram_rd_data : reg_rd_data;

endmodule

`default_nettype wire

// File: hdl/sd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sd_bridge import soc_bus_pkg::*; (
    input  wire         CLOCK_50,
    input  wire         KEY0,
    input  logic        sector_wr,
    input  logic        start_wr,
    input  bus_data_t   wdata,
    input  logic [8:0]  buf_offset,
    input  logic        sd_ready,
    input  logic [7:0]  sd_byte,
    input  logic        sd_byte_valid,
    output logic [31:0] sd_sector,
    output logic        sd_rd_start,
    output bus_data_t   buf_data,
    output logic        sd_avail,
    output logic        sd_ready_q
);

    localparam int CNT_W = $clog2(SD_BUF_BYTES);

    logic [7:0]       sd_buf [SD_BUF_BYTES];
    logic [CNT_W-1:0] byte_cnt;
    logic             byte_valid_d;
    logic             byte_edge;
    logic             ready_meta;

    assign byte_edge = sd_byte_valid && !byte_valid_d;

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            sd_buf[byte_cnt] <= sd_byte;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_sector    <= 32'd0;
            sd_rd_start  <= 1'b0;
            byte_cnt     <= '0;
            byte_valid_d <= 1'b0;
            sd_avail     <= 1'b0;
            ready_meta   <= 1'b0;
            sd_ready_q   <= 1'b0;
        end else begin
            sd_rd_start  <= start_wr;
            byte_valid_d <= sd_byte_valid;
            ready_meta   <= sd_ready;
            sd_ready_q   <= ready_meta;

            if (sector_wr) begin
                sd_sector <= wdata[31:0];
            end

            // count wraps to zero after the last byte of a sector
            if (byte_edge) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == CNT_W'(SD_BUF_BYTES - 1)) begin
                    sd_avail <= 1'b1;
                end else if (byte_cnt == '0) begin
                    sd_avail <= 1'b0;
                end
            end
        end
    end

    // eight bytes from buf_offset, zero past the end
    always_comb begin
        logic [9:0] pos;
        for (int i = 0; i < 8; i++) begin
            pos = {1'b0, buf_offset} + 10'(i);
            buf_data[8*i +: 8] = (pos < SD_BUF_BYTES) ? sd_buf[pos[8:0]] : 8'd0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/keyboard_port.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_port (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  logic [7:0] key_ascii,
    input  logic       key_pressed,
    input  logic       irq_ack,
    output logic [7:0] key_code,
    output logic       irq
);

    logic pressed_d;
    logic press_edge;

    // one cycle per new press
    assign press_edge = key_pressed && !pressed_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pressed_d <= 1'b0;
            key_code  <= 8'd0;
            irq       <= 1'b0;
        end else begin
            pressed_d <= key_pressed;

            if (press_edge) begin
                key_code <= key_ascii;
            end

            // ack beats a press in the same cycle
            if (irq_ack) begin
                irq <= 1'b0;
            end else if (press_edge && key_ascii != 8'd0) begin
                irq <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import soc_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  wire       CLOCK_50,
    input  wire       KEY0,
    input  logic      ram_rd,
    input  logic      ram_wr,
    input  bus_req_t  req,
    output logic      ram_rd_done,
    output bus_data_t ram_rd_data,
    output logic      ram_wr_done
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0] mem [RAM_WORDS];

    bus_addr_t        ram_off;
    logic [IDX_W-1:0] idx;
    logic [3:0]       wr_be;
    logic [31:0]      wr_word;

    // read pipeline
    logic [IDX_W-1:0] rd_idx;
    access_t          rd_size;
    logic [1:0]       rd_off;
    logic             rd_go;
    logic             rd_hi;
    logic [31:0]      word_q;
    logic [31:0]      word_lo;
    logic [31:0]      shifted;

    // second beat of sd
    logic [IDX_W-1:0] wr_idx;
    logic             wr_hi;

    assign ram_off = req.addr - RAM_BASE;
    assign idx     = ram_off[IDX_W+1:2];

    always_comb begin
        case (req.size[1:0])
            2'd0:    wr_be = 4'b0001 << req.addr[1:0];
            2'd1:    wr_be = 4'b0011 << req.addr[1:0];
            default: wr_be = 4'b1111;
        endcase
        wr_word = req.wdata[31:0] << {req.addr[1:0], 3'b000};
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem[idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
            wr_idx <= idx + 1'b1;
        end else if (wr_hi) begin
            mem[wr_idx] <= req.wdata[63:32];
        end

        if (ram_rd) begin
            rd_idx  <= idx;
            rd_size <= req.size;
            rd_off  <= req.addr[1:0];
        end else if (rd_go) begin
            word_q  <= mem[rd_idx];
            // previous word becomes the low half of an ld
            word_lo <= word_q;
            if (rd_size == ACC_LD && !rd_hi) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_go       <= 1'b0;
            rd_hi       <= 1'b0;
            wr_hi       <= 1'b0;
            ram_rd_done <= 1'b0;
            ram_wr_done <= 1'b0;
        end else begin
            ram_rd_done <= 1'b0;
            ram_wr_done <= 1'b0;
            if (ram_rd) begin
                rd_go <= 1'b1;
                rd_hi <= 1'b0;
            end else if (rd_go) begin
                if (rd_size == ACC_LD && !rd_hi) begin
                    rd_hi <= 1'b1;
                end else begin
                    rd_go       <= 1'b0;
                    rd_hi       <= 1'b0;
                    ram_rd_done <= 1'b1;
                end
            end
            if (ram_wr) begin
                if (req.size == ACC_LD) begin
                    wr_hi <= 1'b1;
                end else begin
                    ram_wr_done <= 1'b1;
                end
            end else if (wr_hi) begin
                wr_hi       <= 1'b0;
                ram_wr_done <= 1'b1;
            end
        end
    end

    // little-endian extract and extend
    always_comb begin
        shifted = word_q >> {rd_off, 3'b000};
        case (rd_size)
            ACC_LB:  ram_rd_data = {{56{shifted[7]}}, shifted[7:0]};
            ACC_LH:  ram_rd_data = {{48{shifted[15]}}, shifted[15:0]};
            ACC_LW:  ram_rd_data = {{32{word_q[31]}}, word_q};
            ACC_LD:  ram_rd_data = {word_q, word_lo};
            ACC_LBU: ram_rd_data = {56'd0, shifted[7:0]};
            ACC_LHU: ram_rd_data = {48'd0, shifted[15:0]};
            ACC_LWU: ram_rd_data = {32'd0, word_q};
            default: ram_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;

    // load/store type field as the core encodes it
    typedef logic [2:0] access_t;

    // stores reuse lb..ld as sb..sd
    localparam access_t ACC_LB  = 3'd0;
    localparam access_t ACC_LH  = 3'd1;
    localparam access_t ACC_LW  = 3'd2;
    localparam access_t ACC_LD  = 3'd3;
    localparam access_t ACC_LBU = 3'd4;
    localparam access_t ACC_LHU = 3'd5;
    localparam access_t ACC_LWU = 3'd6;

    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        access_t   size;
    } bus_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] char;
    } console_t;

    // board address map
    localparam bus_addr_t RAM_BASE       = 64'h0000_1000;
    localparam bus_addr_t SD_BUF_BASE    = 64'h0000_8000;
    localparam bus_addr_t KEY_ADDR       = 64'h0000_9000;
    localparam bus_addr_t CONSOLE_ADDR   = 64'h0000_9008;
    localparam bus_addr_t SD_SECTOR_ADDR = 64'h0000_9010;
    localparam bus_addr_t SD_START_ADDR  = 64'h0000_9018;
    localparam bus_addr_t SD_READY_ADDR  = 64'h0000_9020;
    localparam bus_addr_t SD_AVAIL_ADDR  = 64'h0000_9028;

    localparam int SD_BUF_BYTES = 512;

endpackage

`default_nettype wire
